// ==== source/icache_defines.svh ====
// geometry is fixed; index and block offset must fit in the page offset for VIPT lookup
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// cache shape
`define ICACHE_SETS 64
`define ICACHE_WAYS 4
`define ICACHE_DWORD_W 64
`define ICACHE_INSTR_W 32

// address widths
`define ICACHE_PADDR_W 32
`define ICACHE_VADDR_W 32
`define ICACHE_PAGE_OFF_W 12

// derived field widths, log2 values kept in step with the shape above
`define ICACHE_BYTE_OFF_W 3
`define ICACHE_WORD_OFF_W 2
`define ICACHE_INDEX_W 6
`define ICACHE_WAY_ID_W 2
`define ICACHE_BLOCK_OFF_W (`ICACHE_WORD_OFF_W + `ICACHE_BYTE_OFF_W)
`define ICACHE_TAG_W (`ICACHE_PADDR_W - `ICACHE_INDEX_W - `ICACHE_BLOCK_OFF_W)
`define ICACHE_VTAG_W (`ICACHE_VADDR_W - `ICACHE_INDEX_W - `ICACHE_BLOCK_OFF_W)
`define ICACHE_PTAG_W (`ICACHE_PADDR_W - `ICACHE_PAGE_OFF_W)

// array entries
`define ICACHE_COH_W 1
`define ICACHE_LRU_W (`ICACHE_WAYS - 1)
`define ICACHE_BANK_ADDR_W (`ICACHE_INDEX_W + `ICACHE_WORD_OFF_W)

`endif

// ==== source/icache_geom_pkg.sv ====
// address fields follow the fixed geometry; array commands carry one access per cycle
`default_nettype none
`include "icache_defines.svh"

package icache_geom_pkg;

  typedef logic [`ICACHE_INDEX_W-1:0] index_t;
  typedef logic [`ICACHE_WAY_ID_W-1:0] way_id_t;
  typedef logic [`ICACHE_LRU_W-1:0] lru_bits_t;
  typedef logic [`ICACHE_BANK_ADDR_W-1:0] bank_addr_t;

  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0]      tag;
    index_t                        index;
    logic [`ICACHE_WORD_OFF_W-1:0] word_off;
    logic [`ICACHE_BYTE_OFF_W-1:0] byte_off;
  } paddr_t;

  typedef struct packed {
    logic [`ICACHE_VTAG_W-1:0]     tag;
    index_t                        index;
    logic [`ICACHE_WORD_OFF_W-1:0] word_off;
    logic [`ICACHE_BYTE_OFF_W-1:0] byte_off;
  } vaddr_t;

  typedef struct packed {
    logic [`ICACHE_COH_W-1:0] state;
    logic [`ICACHE_TAG_W-1:0] tag;
  } tag_entry_t;

  typedef tag_entry_t [`ICACHE_WAYS-1:0] tag_row_t;
  typedef logic [`ICACHE_WAYS-1:0][`ICACHE_DWORD_W-1:0] dword_row_t;

  // array ports, a read when w is low
  typedef struct packed {
    logic                    v;
    logic                    w;
    index_t                  index;
    logic [`ICACHE_WAYS-1:0] mask;
    tag_row_t                data;
  } tag_cmd_t;

  typedef struct packed {
    logic                          v;
    logic                          w;
    bank_addr_t [`ICACHE_WAYS-1:0] addr;
    dword_row_t                    data;
  } bank_cmd_t;

  typedef struct packed {
    logic      v;
    logic      w;
    index_t    index;
    lru_bits_t mask;
    lru_bits_t data;
  } lru_cmd_t;

endpackage

`default_nettype wire

// ==== source/icache_msg_pkg.sv ====
// messages toward the miss controller and fill packets from it; only two coherence states
`default_nettype none
`include "icache_defines.svh"

package icache_msg_pkg;

  typedef enum logic [`ICACHE_COH_W-1:0] {
    e_coh_invalid = 1'b0,
    e_coh_shared  = 1'b1
  } coh_state_e;

  typedef enum logic [1:0] {
    e_tag_clear_set  = 2'd0,
    e_tag_invalidate = 2'd1,
    e_tag_set_tag    = 2'd2
  } tag_op_e;

  typedef struct packed {
    icache_geom_pkg::paddr_t paddr;
  } miss_req_t;

  typedef struct packed {
    icache_geom_pkg::way_id_t way;
  } miss_meta_t;

  // block words in natural order, rotation happens at the banks
  typedef struct packed {
    icache_geom_pkg::index_t     index;
    icache_geom_pkg::way_id_t    way;
    icache_geom_pkg::dword_row_t block;
  } data_fill_t;

  typedef struct packed {
    tag_op_e                  op;
    icache_geom_pkg::index_t  index;
    icache_geom_pkg::way_id_t way;
    coh_state_e               state;
    logic [`ICACHE_TAG_W-1:0] tag;
  } tag_fill_t;

endpackage

`default_nettype wire

// ==== source/icache_lookup.sv ====
// holds one deferred LRU clear; a second clear_set during a busy LRU port replaces it
`default_nettype none
`include "icache_defines.svh"

module icache_lookup (
  input  wire logic                         clk_i,
  input  wire logic                         reset_i,
  input  wire icache_geom_pkg::vaddr_t      vaddr_i,
  input  wire logic                         vaddr_v_i,
  input  wire logic                         fetch_ready_i,
  input  wire icache_msg_pkg::data_fill_t   data_fill_i,
  input  wire logic                         data_fill_v_i,
  input  wire icache_msg_pkg::tag_fill_t    tag_fill_i,
  input  wire logic                         tag_fill_v_i,
  input  wire logic                         lru_busy_i,
  output logic                              data_fill_ready_o,
  output logic                              tag_fill_ready_o,
  output logic                              tl_v_o,
  output icache_geom_pkg::vaddr_t           tl_vaddr_o,
  output icache_geom_pkg::tag_cmd_t         tag_cmd_o,
  output icache_geom_pkg::bank_cmd_t        bank_cmd_o,
  output icache_geom_pkg::lru_cmd_t         lru_clr_o
);

  logic                    fetch_accept;
  logic                    data_fill_fire;
  logic                    tag_fill_fire;
  logic                    clr_new;
  logic                    clr_defer;
  logic                    clr_pend_r;
  icache_geom_pkg::index_t clr_index_r;
  logic [`ICACHE_WAYS-1:0] way_onehot;

  assign fetch_accept      = vaddr_v_i & fetch_ready_i;
  assign data_fill_ready_o = ~fetch_accept;
  assign tag_fill_ready_o  = ~fetch_accept;
  assign data_fill_fire    = data_fill_v_i & ~fetch_accept;
  assign tag_fill_fire     = tag_fill_v_i & ~fetch_accept;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_o <= 1'b0;
    end else begin
      tl_v_o <= fetch_accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_accept) begin
      tl_vaddr_o <= vaddr_i;
    end
  end

  // fetch reads word_off of every bank, fills rotate words by way
  always_comb begin
    bank_cmd_o = '0;
    if (fetch_accept) begin
      bank_cmd_o.v = 1'b1;
      for (int b = 0; b < `ICACHE_WAYS; b++) begin
        bank_cmd_o.addr[b] = {vaddr_i.index, vaddr_i.word_off};
      end
    end else if (data_fill_fire) begin
      bank_cmd_o.v = 1'b1;
      bank_cmd_o.w = 1'b1;
      for (int b = 0; b < `ICACHE_WAYS; b++) begin
        bank_cmd_o.addr[b] = {data_fill_i.index, data_fill_i.way ^ `ICACHE_WAY_ID_W'(b)};
        bank_cmd_o.data[b] = data_fill_i.block[data_fill_i.way ^ `ICACHE_WAY_ID_W'(b)];
      end
    end
  end

  assign way_onehot = `ICACHE_WAYS'(1) << tag_fill_i.way;

  always_comb begin
    tag_cmd_o = '0;
    if (fetch_accept) begin
      tag_cmd_o.v     = 1'b1;
      tag_cmd_o.index = vaddr_i.index;
    end else if (tag_fill_fire) begin
      tag_cmd_o.v     = 1'b1;
      tag_cmd_o.w     = 1'b1;
      tag_cmd_o.index = tag_fill_i.index;
      case (tag_fill_i.op)
        icache_msg_pkg::e_tag_clear_set: tag_cmd_o.mask = '1;
        icache_msg_pkg::e_tag_invalidate: tag_cmd_o.mask = way_onehot;
        icache_msg_pkg::e_tag_set_tag: begin
          tag_cmd_o.mask = way_onehot;
          for (int i = 0; i < `ICACHE_WAYS; i++) begin
            tag_cmd_o.data[i] = {tag_fill_i.state, tag_fill_i.tag};
          end
        end
        default: tag_cmd_o = '0;
      endcase
    end
  end

  // lru clear waits for an idle verify stage
  assign clr_new   = tag_fill_fire & (tag_fill_i.op == icache_msg_pkg::e_tag_clear_set);
  assign clr_defer = clr_new & (lru_busy_i | clr_pend_r);

  always_comb begin
    lru_clr_o       = '0;
    lru_clr_o.v     = ~lru_busy_i & (clr_pend_r | clr_new);
    lru_clr_o.w     = 1'b1;
    lru_clr_o.index = clr_pend_r ? clr_index_r : tag_fill_i.index;
    lru_clr_o.mask  = '1;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      clr_pend_r <= 1'b0;
    end else if (clr_defer) begin
      clr_pend_r <= 1'b1;
    end else if (lru_clr_o.v) begin
      clr_pend_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (clr_defer) begin
      clr_index_r <= tag_fill_i.index;
    end
  end

  a_fetch_blocks_fill: assert property (@(posedge clk_i) disable iff (reset_i)
    fetch_accept |-> !bank_cmd_o.w && !tag_cmd_o.w);

endmodule

`default_nettype wire

// ==== source/icache_arrays.sv ====
// single port arrays without reset, contents undefined until every set gets a clear_set
`default_nettype none
`include "icache_defines.svh"

module icache_arrays (
  input  wire logic                       clk_i,
  input  wire logic                       reset_i,
  input  wire icache_geom_pkg::tag_cmd_t  tag_cmd_i,
  input  wire icache_geom_pkg::bank_cmd_t bank_cmd_i,
  input  wire icache_geom_pkg::lru_cmd_t  lru_cmd_i,
  input  wire icache_geom_pkg::lru_cmd_t  lru_clr_i,
  output icache_geom_pkg::tag_row_t       tag_row_o,
  output icache_geom_pkg::dword_row_t     bank_row_o,
  output icache_geom_pkg::lru_bits_t      lru_rd_o
);

  icache_geom_pkg::tag_row_t  tag_mem [`ICACHE_SETS];
  icache_geom_pkg::lru_bits_t lru_mem [`ICACHE_SETS];
  icache_geom_pkg::lru_cmd_t  lru_port;

  // tag array, per-way write mask
  always_ff @(posedge clk_i) begin
    if (~reset_i & tag_cmd_i.v) begin
      if (tag_cmd_i.w) begin
        for (int i = 0; i < `ICACHE_WAYS; i++) begin
          if (tag_cmd_i.mask[i]) begin
            tag_mem[tag_cmd_i.index][i] <= tag_cmd_i.data[i];
          end
        end
      end else begin
        tag_row_o <= tag_mem[tag_cmd_i.index];
      end
    end
  end

  // bank b holds word (way ^ b) of each way's block
  for (genvar b = 0; b < `ICACHE_WAYS; b++) begin : g_bank
    logic [`ICACHE_DWORD_W-1:0] bank_mem [`ICACHE_SETS*`ICACHE_WAYS];
    logic [`ICACHE_DWORD_W-1:0] rd_r;

    always_ff @(posedge clk_i) begin
      if (~reset_i & bank_cmd_i.v) begin
        if (bank_cmd_i.w) begin
          bank_mem[bank_cmd_i.addr[b]] <= bank_cmd_i.data[b];
        end else begin
          rd_r <= bank_mem[bank_cmd_i.addr[b]];
        end
      end
    end

    assign bank_row_o[b] = rd_r;
  end

  // deferred clear only arrives while the verify stage is idle
  assign lru_port = lru_clr_i.v ? lru_clr_i : lru_cmd_i;

  always_ff @(posedge clk_i) begin
    if (~reset_i & lru_port.v) begin
      if (lru_port.w) begin
        for (int k = 0; k < `ICACHE_LRU_W; k++) begin
          if (lru_port.mask[k]) begin
            lru_mem[lru_port.index][k] <= lru_port.data[k];
          end
        end
      end else begin
        lru_rd_o <= lru_mem[lru_port.index];
      end
    end
  end

  a_lru_single_access: assert property (@(posedge clk_i) disable iff (reset_i)
    !(lru_cmd_i.v && lru_clr_i.v));

endmodule

`default_nettype wire

// ==== source/icache_verify.sv ====
// a miss seen while one is outstanding, or with miss_req_ready_i low, raises miss_o but no request
`default_nettype none
`include "icache_defines.svh"

module icache_verify (
  input  wire logic                        clk_i,
  input  wire logic                        reset_i,
  input  wire logic                        tl_v_i,
  input  wire icache_geom_pkg::vaddr_t     tl_vaddr_i,
  input  wire logic [`ICACHE_PTAG_W-1:0]   ptag_i,
  input  wire logic                        ptag_v_i,
  input  wire logic                        poison_i,
  input  wire icache_geom_pkg::tag_row_t   tag_row_i,
  input  wire icache_geom_pkg::dword_row_t bank_row_i,
  input  wire icache_geom_pkg::lru_bits_t  lru_rd_i,
  input  wire logic                        miss_req_ready_i,
  input  wire logic                        fill_done_i,
  output logic [`ICACHE_INSTR_W-1:0]       data_o,
  output logic                             data_v_o,
  output logic                             miss_o,
  output icache_msg_pkg::miss_req_t        miss_req_o,
  output logic                             miss_req_v_o,
  output icache_msg_pkg::miss_meta_t       miss_meta_o,
  output logic                             miss_meta_v_o,
  output logic                             fetch_ready_o,
  output icache_geom_pkg::lru_cmd_t        lru_cmd_o,
  output logic                             lru_busy_o
);

  logic                        tv_we;
  logic                        tv_v_r;
  icache_geom_pkg::paddr_t     tv_paddr_r;
  icache_geom_pkg::tag_row_t   tv_tag_r;
  icache_geom_pkg::dword_row_t tv_bank_r;
  logic [`ICACHE_WAYS-1:0]     hit_v;
  logic [`ICACHE_WAYS-1:0]     way_inv;
  logic                        hit;
  icache_geom_pkg::way_id_t    hit_way;
  icache_geom_pkg::way_id_t    inv_way;
  logic [`ICACHE_DWORD_W-1:0]  hit_dword;
  logic                        outstanding_r;
  logic                        meta_v_r;
  logic                        inv_exist_r;
  icache_geom_pkg::way_id_t    inv_way_r;
  icache_geom_pkg::way_id_t    lru_way;

  assign tv_we = tl_v_i & ptag_v_i & ~poison_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tv_v_r <= 1'b0;
    end else begin
      tv_v_r <= tv_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tv_we) begin
      tv_paddr_r <= {ptag_i, tl_vaddr_i[`ICACHE_PAGE_OFF_W-1:0]};
      tv_tag_r   <= tag_row_i;
      tv_bank_r  <= bank_row_i;
    end
  end

  // lowest way wins for both hit and invalid
  always_comb begin
    hit_v   = '0;
    way_inv = '0;
    hit_way = '0;
    inv_way = '0;
    for (int i = `ICACHE_WAYS - 1; i >= 0; i--) begin
      way_inv[i] = (tv_tag_r[i].state == icache_msg_pkg::e_coh_invalid);
      hit_v[i]   = ~way_inv[i] & (tv_tag_r[i].tag == tv_paddr_r.tag);
      if (hit_v[i]) begin
        hit_way = `ICACHE_WAY_ID_W'(i);
      end
      if (way_inv[i]) begin
        inv_way = `ICACHE_WAY_ID_W'(i);
      end
    end
  end

  assign hit = |hit_v;

  assign hit_dword = tv_bank_r[hit_way ^ tv_paddr_r.word_off];
  assign data_o    = tv_paddr_r.byte_off[`ICACHE_BYTE_OFF_W-1]
                   ? hit_dword[2*`ICACHE_INSTR_W-1 -: `ICACHE_INSTR_W]
                   : hit_dword[`ICACHE_INSTR_W-1:0];
  assign data_v_o  = tv_v_r & hit;
  assign miss_o    = tv_v_r & ~hit;

  assign miss_req_v_o     = miss_o & miss_req_ready_i & ~outstanding_r;
  assign miss_req_o.paddr = tv_paddr_r;
  assign fetch_ready_o    = miss_req_ready_i & ~miss_req_v_o & ~outstanding_r;

  // read on miss for the victim, tree update on hit
  always_comb begin
    lru_cmd_o       = '0;
    lru_cmd_o.v     = tv_v_r;
    lru_cmd_o.w     = tv_v_r & hit;
    lru_cmd_o.index = tv_paddr_r.index;
    lru_cmd_o.mask  = {hit_way[1], ~hit_way[1], 1'b1};
    lru_cmd_o.data  = {~hit_way[0], ~hit_way[0], ~hit_way[1]};
  end

  assign lru_busy_o = tv_v_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      meta_v_r      <= 1'b0;
      outstanding_r <= 1'b0;
    end else begin
      meta_v_r <= miss_req_v_o;
      if (miss_req_v_o) begin
        outstanding_r <= 1'b1;
      end else if (fill_done_i) begin
        outstanding_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_req_v_o) begin
      inv_exist_r <= |way_inv;
      inv_way_r   <= inv_way;
    end
  end

  // root bit picks the half, then that half's node picks the way
  assign lru_way         = lru_rd_i[0] ? {1'b1, lru_rd_i[2]} : {1'b0, lru_rd_i[1]};
  assign miss_meta_o.way = inv_exist_r ? inv_way_r : lru_way;
  assign miss_meta_v_o   = meta_v_r;

  a_meta_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_meta_v_o == $past(miss_req_v_o));

  a_one_req_per_fill: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_req_v_o |=> !miss_req_v_o throughout fill_done_i [->1]);

endmodule

`default_nettype wire

// ==== source/icache_top.sv ====
// ptag_i must arrive the cycle after a fetch is accepted; the miss controller pulses fill_done_i
`default_nettype none
`include "icache_defines.svh"

module icache_top (
  input  wire logic                       clk_i,
  input  wire logic                       reset_i,
  input  wire icache_geom_pkg::vaddr_t    vaddr_i,
  input  wire logic                       vaddr_v_i,
  output logic                            vaddr_ready_o,
  input  wire logic [`ICACHE_PTAG_W-1:0]  ptag_i,
  input  wire logic                       ptag_v_i,
  input  wire logic                       poison_i,
  output logic [`ICACHE_INSTR_W-1:0]      data_o,
  output logic                            data_v_o,
  output logic                            miss_o,
  output icache_msg_pkg::miss_req_t       miss_req_o,
  output logic                            miss_req_v_o,
  input  wire logic                       miss_req_ready_i,
  output icache_msg_pkg::miss_meta_t      miss_meta_o,
  output logic                            miss_meta_v_o,
  input  wire logic                       fill_done_i,
  input  wire icache_msg_pkg::data_fill_t data_fill_i,
  input  wire logic                       data_fill_v_i,
  output logic                            data_fill_ready_o,
  input  wire icache_msg_pkg::tag_fill_t  tag_fill_i,
  input  wire logic                       tag_fill_v_i,
  output logic                            tag_fill_ready_o
);

  logic                        tl_v;
  icache_geom_pkg::vaddr_t     tl_vaddr;
  icache_geom_pkg::tag_cmd_t   tag_cmd;
  icache_geom_pkg::bank_cmd_t  bank_cmd;
  icache_geom_pkg::lru_cmd_t   lru_clr;
  icache_geom_pkg::lru_cmd_t   lru_cmd;
  logic                        lru_busy;
  icache_geom_pkg::tag_row_t   tag_row;
  icache_geom_pkg::dword_row_t bank_row;
  icache_geom_pkg::lru_bits_t  lru_rd;

  icache_lookup lookup_i (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .vaddr_i           (vaddr_i),
    .vaddr_v_i         (vaddr_v_i),
    .fetch_ready_i     (vaddr_ready_o),
    .data_fill_i       (data_fill_i),
    .data_fill_v_i     (data_fill_v_i),
    .tag_fill_i        (tag_fill_i),
    .tag_fill_v_i      (tag_fill_v_i),
    .lru_busy_i        (lru_busy),
    .data_fill_ready_o (data_fill_ready_o),
    .tag_fill_ready_o  (tag_fill_ready_o),
    .tl_v_o            (tl_v),
    .tl_vaddr_o        (tl_vaddr),
    .tag_cmd_o         (tag_cmd),
    .bank_cmd_o        (bank_cmd),
    .lru_clr_o         (lru_clr)
  );

  icache_arrays arrays_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .tag_cmd_i  (tag_cmd),
    .bank_cmd_i (bank_cmd),
    .lru_cmd_i  (lru_cmd),
    .lru_clr_i  (lru_clr),
    .tag_row_o  (tag_row),
    .bank_row_o (bank_row),
    .lru_rd_o   (lru_rd)
  );

  icache_verify verify_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .tl_v_i           (tl_v),
    .tl_vaddr_i       (tl_vaddr),
    .ptag_i           (ptag_i),
    .ptag_v_i         (ptag_v_i),
    .poison_i         (poison_i),
    .tag_row_i        (tag_row),
    .bank_row_i       (bank_row),
    .lru_rd_i         (lru_rd),
    .miss_req_ready_i (miss_req_ready_i),
    .fill_done_i      (fill_done_i),
    .data_o           (data_o),
    .data_v_o         (data_v_o),
    .miss_o           (miss_o),
    .miss_req_o       (miss_req_o),
    .miss_req_v_o     (miss_req_v_o),
    .miss_meta_o      (miss_meta_o),
    .miss_meta_v_o    (miss_meta_v_o),
    .fetch_ready_o    (vaddr_ready_o),
    .lru_cmd_o        (lru_cmd),
    .lru_busy_o       (lru_busy)
  );

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
// period of 100 time units, reset held high for the first five rising edges
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #50 clk_o = ~clk_o;
    end
  end

  initial begin
    reset_o = 1'b1;
    repeat (5) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== test/icache_tb.sv ====
// one fetch in flight at a time; miss_req_ready_i stays high and fill_done_i stands in for the refill
`default_nettype none
`include "icache_defines.svh"

module icache_tb;

  typedef enum logic [1:0] {
    k_none,
    k_hit,
    k_miss
  } kind_e;

  typedef struct packed {
    kind_e                       kind;
    int                          due;
    logic [`ICACHE_INSTR_W-1:0]  data;
    logic [`ICACHE_PADDR_W-1:0]  paddr;
    logic [`ICACHE_WAY_ID_W-1:0] way;
  } expect_t;

  localparam int n_fetch = 26;
  localparam int cycle_limit = n_fetch * 40 + 200;

  logic                            clk_i;
  logic                            reset_i;
  icache_geom_pkg::vaddr_t         vaddr_i;
  logic                            vaddr_v_i;
  logic                            vaddr_ready_o;
  logic [`ICACHE_PTAG_W-1:0]       ptag_i;
  logic                            ptag_v_i;
  logic                            poison_i;
  logic [`ICACHE_INSTR_W-1:0]      data_o;
  logic                            data_v_o;
  logic                            miss_o;
  icache_msg_pkg::miss_req_t       miss_req_o;
  logic                            miss_req_v_o;
  logic                            miss_req_ready_i;
  icache_msg_pkg::miss_meta_t      miss_meta_o;
  logic                            miss_meta_v_o;
  logic                            fill_done_i;
  icache_msg_pkg::data_fill_t      data_fill_i;
  logic                            data_fill_v_i;
  logic                            data_fill_ready_o;
  icache_msg_pkg::tag_fill_t       tag_fill_i;
  logic                            tag_fill_v_i;
  logic                            tag_fill_ready_o;

  // model of the cache contents
  logic [`ICACHE_TAG_W-1:0]   m_tag [`ICACHE_SETS][`ICACHE_WAYS];
  logic                       m_valid [`ICACHE_SETS][`ICACHE_WAYS];
  logic [`ICACHE_LRU_W-1:0]   m_lru [`ICACHE_SETS];
  logic [`ICACHE_DWORD_W-1:0] m_bank [`ICACHE_WAYS][`ICACHE_SETS*`ICACHE_WAYS];

  expect_t     exp_q [$];
  logic [15:0] lfsr_state = 16'd14;
  int          errors = 0;
  int          checks = 0;
  int          test_start_errors = 0;
  int          cyc = 0;
  int          cycle_cnt = 0;

  tb_clock clock_gen (
    .clk_o   (clk_i),
    .reset_o (reset_i)
  );

  icache_top dut_i (.*);

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [2:0] lookup_way(input int idx, input logic [`ICACHE_TAG_W-1:0] tag);
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
        return {1'b1, 2'(w)};
      end
    end
    return 3'b000;
  endfunction

  function automatic logic [1:0] victim_way(input int idx);
    logic [2:0] t;
    t = m_lru[idx];
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (!m_valid[idx][w]) begin
        return 2'(w);
      end
    end
    // root names the half, the node of that half names the way
    if (t[0]) begin
      return {1'b1, t[2]};
    end
    return {1'b0, t[1]};
  endfunction

  function automatic logic [2:0] lru_after_hit(input logic [2:0] t, input logic [1:0] w);
    logic [2:0] n;
    n = t;
    n[0] = ~w[1];
    if (w[1]) begin
      n[2] = ~w[0];
    end else begin
      n[1] = ~w[0];
    end
    return n;
  endfunction

  // word wo of the block sits in bank (way ^ wo)
  function automatic logic [31:0] expected_instr(input int idx, input logic [1:0] way,
                                                 input logic [4:0] off);
    logic [1:0]  wo;
    logic [63:0] dw;
    wo = off[4:3];
    dw = m_bank[way ^ wo][idx * 4 + wo];
    return off[2] ? dw[63:32] : dw[31:0];
  endfunction

  task automatic take_bits(input int n, output logic [63:0] r);
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
  endtask

  task automatic compare_value(input string name, input logic [63:0] got, input logic [63:0] want);
    checks++;
    assert (got == want) else begin
      $display("error t=%0t %s got %0h expected %0h", $time, name, got, want);
      errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("failure t=%0t %s", $time, what);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    @(posedge clk_i);
    $display("test %s finished with %0d errors", name, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  task automatic send_tag(input icache_msg_pkg::tag_op_e op, input int idx, input logic [1:0] way,
                          input logic [`ICACHE_TAG_W-1:0] tag);
    icache_msg_pkg::tag_fill_t pkt;
    pkt       = '0;
    pkt.op    = op;
    pkt.index = 6'(idx);
    pkt.way   = way;
    pkt.tag   = tag;
    if (op == icache_msg_pkg::e_tag_set_tag) begin
      pkt.state = icache_msg_pkg::e_coh_shared;
    end
    @(posedge clk_i);
    tag_fill_i   <= pkt;
    tag_fill_v_i <= 1'b1;
    @(negedge clk_i);
    expect_true(tag_fill_ready_o, "tag fill packet was not accepted");
    @(posedge clk_i);
    tag_fill_v_i <= 1'b0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (op == icache_msg_pkg::e_tag_clear_set || w == way) begin
        m_valid[idx][w] = (op == icache_msg_pkg::e_tag_set_tag);
        m_tag[idx][w]   = m_valid[idx][w] ? tag : '0;
      end
    end
    if (op == icache_msg_pkg::e_tag_clear_set) begin
      m_lru[idx] = '0;
    end
  endtask

  task automatic send_data(input int idx, input logic [1:0] way,
                           input icache_geom_pkg::dword_row_t block);
    icache_msg_pkg::data_fill_t pkt;
    logic [1:0]                 word;
    pkt.index = 6'(idx);
    pkt.way   = way;
    pkt.block = block;
    @(posedge clk_i);
    data_fill_i   <= pkt;
    data_fill_v_i <= 1'b1;
    @(negedge clk_i);
    expect_true(data_fill_ready_o, "data fill packet was not accepted");
    @(posedge clk_i);
    data_fill_v_i <= 1'b0;
    for (int b = 0; b < `ICACHE_WAYS; b++) begin
      word = way ^ 2'(b);
      m_bank[b][idx * 4 + word] = block[word];
    end
  endtask

  task automatic fetch(input logic [31:0] va, input logic [19:0] pt, input logic poison);
    logic [31:0] pa;
    int          idx;
    logic [2:0]  hw;
    expect_t     e;
    pa  = {pt, va[11:0]};
    idx = pa[10:5];
    hw  = lookup_way(idx, pa[31:11]);
    @(negedge clk_i);
    while (!vaddr_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    vaddr_i   <= va;
    vaddr_v_i <= 1'b1;
    @(negedge clk_i);
    expect_true(vaddr_ready_o, "fetch was not accepted");
    expect_true(!data_fill_ready_o && !tag_fill_ready_o, "fill port ready while a fetch is taken");
    @(posedge clk_i);
    vaddr_v_i <= 1'b0;
    ptag_i    <= pt;
    ptag_v_i  <= 1'b1;
    poison_i  <= poison;
    e     = '0;
    e.due = cyc + 2;
    if (!poison && hw[2]) begin
      e.kind     = k_hit;
      e.data     = expected_instr(idx, hw[1:0], va[4:0]);
      m_lru[idx] = lru_after_hit(m_lru[idx], hw[1:0]);
    end else if (!poison) begin
      e.kind  = k_miss;
      e.paddr = pa;
      e.way   = victim_way(idx);
    end
    exp_q.push_back(e);
    @(posedge clk_i);
    ptag_v_i <= 1'b0;
    poison_i <= 1'b0;
  endtask

  task automatic wait_hit();
    @(negedge clk_i);
    while (!data_v_o) begin
      @(negedge clk_i);
    end
  endtask

  // ready stays low from the request until the cycle after fill_done_i
  task automatic finish_miss();
    @(negedge clk_i);
    while (!miss_o) begin
      @(negedge clk_i);
    end
    expect_true(!vaddr_ready_o, "vaddr_ready_o high in the miss request cycle");
    repeat (3) begin
      @(negedge clk_i);
      expect_true(!vaddr_ready_o, "vaddr_ready_o high while a miss is outstanding");
    end
    @(posedge clk_i);
    fill_done_i <= 1'b1;
    @(negedge clk_i);
    expect_true(!vaddr_ready_o, "vaddr_ready_o high in the fill_done_i cycle");
    @(posedge clk_i);
    fill_done_i <= 1'b0;
    @(negedge clk_i);
    expect_true(vaddr_ready_o, "vaddr_ready_o did not return after fill_done_i");
  endtask

  initial begin : compare_results
    expect_t                  e;
    int                       meta_due;
    icache_geom_pkg::way_id_t meta_way;
    meta_due = -1;
    meta_way = '0;
    forever begin
      @(negedge clk_i);
      cyc++;
      if (!reset_i) begin
        e = '0;
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
          e = exp_q.pop_front();
        end
        compare_value("data_v_o", data_v_o, e.kind == k_hit);
        compare_value("miss_o", miss_o, e.kind == k_miss);
        if (e.kind == k_hit) begin
          compare_value("data_o", data_o, e.data);
        end
        if (e.kind == k_miss) begin
          compare_value("miss_req_v_o", miss_req_v_o, 1'b1);
          compare_value("miss_req_o", miss_req_o, e.paddr);
          meta_due = cyc + 1;
          meta_way = e.way;
        end
        compare_value("miss_meta_v_o", miss_meta_v_o, meta_due == cyc);
        if (meta_due == cyc) begin
          compare_value("miss_meta_o", miss_meta_o, meta_way);
        end
      end
    end
  end

  initial begin : watchdog
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: the run did not end within %0d cycles", cycle_limit);
    $display("Some tests failed");
    $finish;
  end

  initial begin : stimulus
    logic [63:0]                 r;
    logic [31:0]                 va2;
    logic [31:0]                 va3;
    logic [19:0]                 pt2;
    logic [19:0]                 pt3;
    int                          s2;
    int                          s3;
    logic [1:0]                  w2;
    logic [1:0]                  w4;
    icache_geom_pkg::dword_row_t block;
    vaddr_i          = '0;
    vaddr_v_i        = 1'b0;
    ptag_i           = '0;
    ptag_v_i         = 1'b0;
    poison_i         = 1'b0;
    miss_req_ready_i = 1'b1;
    fill_done_i      = 1'b0;
    data_fill_i      = '0;
    data_fill_v_i    = 1'b0;
    tag_fill_i       = '0;
    tag_fill_v_i     = 1'b0;
    wait (reset_i === 1'b0);

    for (int s = 0; s < `ICACHE_SETS; s++) begin
      send_tag(icache_msg_pkg::e_tag_clear_set, s, 2'd0, '0);
    end
    for (int i = 0; i < 8; i++) begin
      take_bits(52, r);
      fetch(r[51:20], r[19:0], 1'b0);
      finish_miss();
    end
    end_test("miss after clear_set");

    take_bits(32, r);
    va2 = {r[31:5], 5'b0};
    s2  = va2[10:5];
    take_bits(22, r);
    pt2 = r[19:0];
    w2  = r[21:20];
    for (int k = 0; k < `ICACHE_WAYS; k++) begin
      take_bits(64, r);
      block[k] = r;
    end
    send_data(s2, w2, block);
    send_tag(icache_msg_pkg::e_tag_set_tag, s2, w2, {pt2, va2[11]});
    for (int i = 0; i < 8; i++) begin
      fetch(va2 + 32'(i * 4), pt2, 1'b0);
      wait_hit();
    end
    end_test("hit on every instruction of a block");

    // neighbour set, all four ways valid with tags pt3 + way
    s3  = (s2 + 1) % `ICACHE_SETS;
    va3 = {va2[31:11], 6'(s3), 5'b0};
    take_bits(20, r);
    pt3 = r[19:0];
    for (int k = 0; k < `ICACHE_WAYS; k++) begin
      for (int j = 0; j < `ICACHE_WAYS; j++) begin
        take_bits(64, r);
        block[j] = r;
      end
      send_data(s3, 2'(k), block);
      send_tag(icache_msg_pkg::e_tag_set_tag, s3, 2'(k), {pt3 + 20'(k), va3[11]});
    end
    for (int i = 0; i < 6; i++) begin
      take_bits(5, r);
      fetch({va3[31:5], r[2:0], 2'b00}, pt3 + 20'(r[4:3]), 1'b0);
      wait_hit();
    end
    fetch(va3, pt3 + 20'd4, 1'b0);
    finish_miss();
    end_test("victim from the pseudo-LRU tree");

    take_bits(2, r);
    w4 = r[1:0];
    // never the way the tree would pick anyway
    if (w4 == victim_way(s3)) begin
      w4 = ~w4;
    end
    send_tag(icache_msg_pkg::e_tag_invalidate, s3, w4, '0);
    fetch(va3, pt3 + 20'(w4), 1'b0);
    finish_miss();
    end_test("invalid way chosen before the LRU way");

    fetch(va2 + 32'd12, pt2, 1'b1);
    repeat (2) @(negedge clk_i);
    fetch(va2 + 32'd12, pt2, 1'b0);
    wait_hit();
    end_test("poisoned fetch dropped");

    repeat (3) @(negedge clk_i);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/icache_geom_pkg.sv
source/icache_msg_pkg.sv
source/icache_lookup.sv
source/icache_arrays.sv
source/icache_verify.sv
source/icache_top.sv
test/tb_clock.sv
test/icache_tb.sv
